/* tuple_lag_top.f */
hw/tuple_pkg.sv
hw/tuple_fifo.sv
hw/tuple_joiner.sv
hw/lag_status.sv
hw/tuple_lag_top.sv
sim/tuple_lag_assert.sv
sim/tuple_lag_tb.sv

/* sim/tuple_lag_tb.sv */
`default_nettype none

// directed testbench for the tuple lag pairer
module tuple_lag_tb
   import tuple_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int A_PRELOAD   = 4;   // matches the dut default
   localparam int DEPTH       = 8;   // 2^ADDR_W with the default ADDR_W
   localparam int TEST_CYCLES = 100; // about 80 cycles of tests, rounded up
   localparam int SUM_TIMEOUT = 50;  // cycles allowed while waiting for sums

   logic       i_clk;
   logic       i_rst;
   logic       i_a_write;
   tuple_t     i_a_item;
   logic       i_b_write;
   tuple_t     i_b_item;
   logic       i_clear_status;
   sum_t       o_sum;
   logic       o_sum_valid;
   logic       o_a_full;
   logic       o_b_full;
   ovr_flags_t o_ovr;
   count_t     o_joined;

   tuple_t qa[$];      // model of stream a, lag included
   tuple_t qb[$];      // model of stream b
   int     sum_count;  // sums seen since reset
   int     exp_sums;   // sums the model expects since reset
   int     errors;

   tuple_lag_top dut (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_a_write      (i_a_write),
      .i_a_item       (i_a_item),
      .i_b_write      (i_b_write),
      .i_b_item       (i_b_item),
      .i_clear_status (i_clear_status),
      .o_sum          (o_sum),
      .o_sum_valid    (o_sum_valid),
      .o_a_full       (o_a_full),
      .o_b_full       (o_b_full),
      .o_ovr          (o_ovr),
      .o_joined       (o_joined)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;  // 4 ns period
   end

   task automatic check_sum(input string name, input sum_t got, input sum_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flags(input string name, input ovr_flags_t got, input ovr_flags_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %0d exp %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   function automatic elem_t rand_elem();
      return {$urandom(), $urandom()};
   endfunction

   // close to 2^64 so that two of them wrap
   function automatic elem_t near_wrap_elem();
      return ~elem_t'($urandom_range(15));
   endfunction

   // sums are checked at the falling edge, long after the outputs settle
   always @(negedge i_clk) begin
      tuple_t ta;
      tuple_t tb;
      sum_t   exp;
      if (!i_rst && o_sum_valid) begin
         if (qa.size() == 0 || qb.size() == 0) begin
            errors++;
            $display("ERROR t=%0t: o_sum_valid with no pending model tuple", $time);
         end else begin
            ta = qa.pop_front();
            tb = qb.pop_front();
            exp.s0 = ta.e0 + tb.e0;  // 64-bit wrap
            exp.s1 = ta.e1 + tb.e1;
            check_sum("o_sum", o_sum, exp);
         end
         sum_count++;
      end
   end

   // one write cycle on either or both streams, model follows accepted items
   task automatic drive_write(input logic wa, input tuple_t a, input logic wb, input tuple_t b,
                              input logic push_b);
      @(posedge i_clk);
      #1;
      i_a_write = wa;
      i_a_item  = a;
      i_b_write = wb;
      i_b_item  = b;
      if (wa) qa.push_back(a);
      if (wb && push_b) qb.push_back(b);
   endtask

   task automatic drive_idle();
      @(posedge i_clk);
      #1;
      i_a_write      = 1'b0;
      i_b_write      = 1'b0;
      i_clear_status = 1'b0;
   endtask

   task automatic wait_sums(input int target);
      int waited;
      waited = 0;
      while (sum_count < target && waited < SUM_TIMEOUT) begin
         @(posedge i_clk);
         waited++;
      end
      if (sum_count < target) begin
         errors++;
         $display("ERROR t=%0t: timed out waiting for sum %0d, saw %0d", $time, target, sum_count);
      end
      repeat (2) @(negedge i_clk);  // let the counter catch up
   endtask

   task automatic test_reset_state();
      @(negedge i_clk);
      check_bit("o_a_full", o_a_full, 1'b0);
      check_bit("o_b_full", o_b_full, 1'b0);
      check_flags("o_ovr", o_ovr, '0);
      check_count("o_joined", o_joined, '0);
      check_bit("o_sum_valid", o_sum_valid, 1'b0);
   endtask

   // b alone passes through while the zero lag drains from a
   task automatic test_preload_lag();
      tuple_t b;
      for (int i = 0; i < 6; i++) begin
         b.e0 = rand_elem();
         b.e1 = rand_elem();
         drive_write(1'b0, '0, 1'b1, b, 1'b1);
      end
      drive_idle();
      exp_sums += A_PRELOAD;  // only the zero lag can pair up
      wait_sums(exp_sums);
      repeat (6) @(posedge i_clk);  // a is empty now, nothing more may come out
      if (sum_count != exp_sums) begin
         errors++;
         $display("ERROR t=%0t: sums kept coming while stream a was empty", $time);
      end
      if (qb.size() != 6 - A_PRELOAD) begin
         errors++;
         $display("ERROR t=%0t: model holds %0d b items, expected 2", $time, qb.size());
      end
   endtask

   task automatic test_paired_stream();
      tuple_t a;
      tuple_t b;
      for (int i = 0; i < 20; i++) begin
         a.e0 = rand_elem();
         a.e1 = rand_elem();
         b.e0 = rand_elem();
         b.e1 = rand_elem();
         if (i % 4 == 0) begin  // both elements wrap
            a.e0 = near_wrap_elem();
            a.e1 = near_wrap_elem();
            b.e0 = near_wrap_elem();
            b.e1 = near_wrap_elem();
         end
         drive_write(1'b1, a, 1'b1, b, 1'b1);
      end
      drive_idle();
      exp_sums += 20;
      wait_sums(exp_sums);
   endtask

   // a idle, so b fills and the extra writes are dropped
   task automatic test_overrun();
      int         free_slots;
      int         n;
      tuple_t     a;
      tuple_t     b;
      ovr_flags_t exp;
      free_slots = DEPTH - qb.size();  // nothing in flight, a is empty
      for (int i = 0; i < free_slots + 8; i++) begin
         b.e0 = rand_elem();
         b.e1 = rand_elem();
         drive_write(1'b0, '0, 1'b1, b, i < free_slots);
      end
      drive_idle();
      repeat (3) @(negedge i_clk);  // pulse, then sticky flag
      exp.a_overrun = 1'b0;
      exp.b_overrun = 1'b1;
      check_bit("o_b_full", o_b_full, 1'b1);
      check_bit("o_a_full", o_a_full, 1'b0);
      check_flags("o_ovr", o_ovr, exp);
      if (sum_count != exp_sums) begin
         errors++;
         $display("ERROR t=%0t: sum produced while stream a was idle", $time);
      end
      n = qb.size();
      for (int i = 0; i < n; i++) begin
         a.e0 = rand_elem();
         a.e1 = rand_elem();
         drive_write(1'b1, a, 1'b0, '0, 1'b0);
      end
      drive_idle();
      exp_sums += n;  // every stored b item meets one a item
      wait_sums(exp_sums);
      check_bit("o_b_full", o_b_full, 1'b0);
   endtask

   task automatic test_count_clear();
      tuple_t a;
      tuple_t b;
      check_count("o_joined", o_joined, count_t'(exp_sums));
      for (int i = 0; i < 5; i++) begin
         a.e0 = rand_elem();
         a.e1 = rand_elem();
         b.e0 = rand_elem();
         b.e1 = rand_elem();
         drive_write(1'b1, a, 1'b1, b, 1'b1);
      end
      drive_idle();
      exp_sums += 5;
      wait_sums(exp_sums);
      check_count("o_joined", o_joined, count_t'(exp_sums));
      @(posedge i_clk);
      #1;
      i_clear_status = 1'b1;
      drive_idle();
      @(negedge i_clk);
      check_count("o_joined", o_joined, '0);
      check_flags("o_ovr", o_ovr, '0);
   endtask

   initial begin
      #(TEST_CYCLES * 4 * 2);
      $display("watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES * 2);
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(69509));
      i_rst          = 1'b1;
      i_a_write      = 1'b0;
      i_a_item       = '0;
      i_b_write      = 1'b0;
      i_b_item       = '0;
      i_clear_status = 1'b0;
      errors         = 0;
      sum_count      = 0;
      exp_sums       = 0;
      for (int i = 0; i < A_PRELOAD; i++) begin
         qa.push_back('0);  // zero tuples waiting in FIFO a
      end
      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      test_reset_state();
      test_preload_lag();
      test_paired_stream();
      test_overrun();
      test_count_clear();
      $display("errors: %0d, sums checked: %0d", errors, sum_count);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim/tuple_lag_assert.sv */
`default_nettype none

// flag and overrun rules of one FIFO, bound into every tuple_fifo
module tuple_lag_assert (
   input logic i_clk,
   input logic i_rst,
   input logic i_write,
   input logic i_read,
   input logic o_empty,
   input logic o_full,
   input logic o_overrun
);

   timeunit 1ns;
   timeprecision 100ps;

   // depth is never zero
   a_full_empty: assert property (@(posedge i_clk) disable iff (i_rst)
      !(o_full && o_empty))
      else $error("FIFO reports full and empty together");

   // a dropped write is flagged one cycle later
   a_drop_flag: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_write && o_full && !i_read) |=> o_overrun)
      else $error("write into full FIFO did not raise o_overrun");

   a_overrun_cause: assert property (@(posedge i_clk) disable iff (i_rst)
      $rose(o_overrun) |-> $past(i_write))
      else $error("o_overrun rose without a preceding write");

endmodule

bind tuple_fifo tuple_lag_assert u_fifo_assert (
   .i_clk     (i_clk),
   .i_rst     (i_rst),
   .i_write   (i_write),
   .i_read    (i_read),
   .o_empty   (o_empty),
   .o_full    (o_full),
   .o_overrun (o_overrun)
);

`default_nettype wire

/* hw/tuple_lag_top.sv */
`default_nettype none

// tuple lag pairer
// stream a is delayed by A_PRELOAD items, then added to stream b item by item
module tuple_lag_top
   import tuple_pkg::*;
#(
   parameter int ADDR_W    = 3,  // FIFO depth 2^ADDR_W
   parameter int A_PRELOAD = 4,  // lag of stream a in items
   parameter int B_PRELOAD = 0
) (
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_a_write,
   input  tuple_t     i_a_item,
   input  logic       i_b_write,
   input  tuple_t     i_b_item,
   input  logic       i_clear_status,
   output sum_t       o_sum,
   output logic       o_sum_valid,
   output logic       o_a_full,
   output logic       o_b_full,
   output ovr_flags_t o_ovr,
   output count_t     o_joined
);

   tuple_t a_head;      // FIFO heads into the joiner
   tuple_t b_head;
   logic   a_empty;
   logic   b_empty;
   logic   a_overrun;   // dropped-write pulses
   logic   b_overrun;
   logic   pop;         // shared read strobe

   // stream a, starts with the lag already queued
   tuple_fifo #(
      .ADDR_W  (ADDR_W),
      .PRELOAD (A_PRELOAD)
   ) u_fifo_a (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_write   (i_a_write),
      .i_item    (i_a_item),
      .i_read    (pop),
      .o_item    (a_head),
      .o_empty   (a_empty),
      .o_full    (o_a_full),
      .o_overrun (a_overrun)
   );

   tuple_fifo #(
      .ADDR_W  (ADDR_W),
      .PRELOAD (B_PRELOAD)
   ) u_fifo_b (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_write   (i_b_write),
      .i_item    (i_b_item),
      .i_read    (pop),
      .o_item    (b_head),
      .o_empty   (b_empty),
      .o_full    (o_b_full),
      .o_overrun (b_overrun)
   );

   tuple_joiner u_joiner (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_a_item    (a_head),
      .i_b_item    (b_head),
      .i_a_empty   (a_empty),
      .i_b_empty   (b_empty),
      .o_pop       (pop),
      .o_sum       (o_sum),
      .o_sum_valid (o_sum_valid)
   );

   // status watches the same valid the outside sees
   lag_status u_status (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_clear_status (i_clear_status),
      .i_a_overrun    (a_overrun),
      .i_b_overrun    (b_overrun),
      .i_sum_valid    (o_sum_valid),
      .o_ovr          (o_ovr),
      .o_joined       (o_joined)
   );

endmodule

`default_nettype wire

/* hw/lag_status.sv */
`default_nettype none

// sticky overrun flags and a count of joined tuples
module lag_status
   import tuple_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_clear_status,  // zeroes flags and counter
   input  logic       i_a_overrun,     // pulse from FIFO a
   input  logic       i_b_overrun,     // pulse from FIFO b
   input  logic       i_sum_valid,     // one joined tuple
   output ovr_flags_t o_ovr,
   output count_t     o_joined
);

   // flags hold until cleared, a pulse in the clear cycle still sets them
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ovr <= '0;
      end else begin
         o_ovr.a_overrun <= (o_ovr.a_overrun && !i_clear_status) || i_a_overrun;
         o_ovr.b_overrun <= (o_ovr.b_overrun && !i_clear_status) || i_b_overrun;
      end
   end

   // joined counter wraps at its width
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_joined <= '0;
      end else if (i_sum_valid) begin
         // a sum in the clear cycle counts as the first one after it
         o_joined <= i_clear_status ? count_t'(1) : count_t'(o_joined + 1'b1);
      end else if (i_clear_status) begin
         o_joined <= '0;
      end
   end

endmodule

`default_nettype wire

/* hw/tuple_joiner.sv */
`default_nettype none

// pairs the heads of both FIFOs and registers their element-wise sum
module tuple_joiner
   import tuple_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_rst,
   input  tuple_t i_a_item,     // head of stream a, lagged by the preload
   input  tuple_t i_b_item,     // head of stream b
   input  logic   i_a_empty,
   input  logic   i_b_empty,
   output logic   o_pop,        // read strobe to both FIFOs
   output sum_t   o_sum,
   output logic   o_sum_valid   // one cycle after the pop
);

   sum_t sum_d;  // combinational sum of the two heads

   // element-wise add, carries out of bit 63 are dropped
   function automatic sum_t add_tuples(input tuple_t a, input tuple_t b);
      sum_t s;
      s.s0 = a.e0 + b.e0;
      s.s1 = a.e1 + b.e1;
      return s;
   endfunction

   // both heads valid, so take one from each
   // never pops an empty FIFO by construction
   assign o_pop = !i_a_empty && !i_b_empty;

   assign sum_d = add_tuples(i_a_item, i_b_item);

   // payload register, only meaningful with o_sum_valid
   always_ff @(posedge i_clk) begin
      if (o_pop) begin
         o_sum <= sum_d;
      end
   end

   // valid follows each pop by one cycle, back to back pops give one per cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_sum_valid <= 1'b0;
      end else begin
         o_sum_valid <= o_pop;
      end
   end

endmodule

`default_nettype wire

/* hw/tuple_fifo.sv */
`default_nettype none

// circular buffer FIFO of tuples, first-word fall-through
// PRELOAD entries of zero are present after reset, 0 gives a plain empty FIFO
module tuple_fifo
   import tuple_pkg::*;
#(
   parameter int ADDR_W  = 3,  // depth is 2^ADDR_W
   parameter int PRELOAD = 0   // zero tuples present after reset, below depth
) (
   input  logic   i_clk,
   input  logic   i_rst,
   input  logic   i_write,    // store i_item at this edge
   input  tuple_t i_item,
   input  logic   i_read,     // advance head, ignored while empty
   output tuple_t o_item,     // head of queue
   output logic   o_empty,
   output logic   o_full,
   output logic   o_overrun   // one-cycle pulse after a dropped write
);

   localparam int DEPTH = 1 << ADDR_W;

   typedef logic [ADDR_W-1:0] ptr_t;  // wraps naturally at depth
   typedef logic [ADDR_W:0]   occ_t;  // holds 0..DEPTH

   tuple_t mem [DEPTH];  // storage array

   ptr_t wr_ptr;      // next slot to write
   ptr_t rd_ptr;      // current head slot
   occ_t occupancy;   // number of stored tuples
   occ_t occ_next;

   logic do_read;     // accepted read
   logic do_write;    // accepted write

   // a read only counts when there is something to read
   assign do_read = i_read && !o_empty;

   // a full FIFO still takes a write when a read frees a slot in the same cycle
   assign do_write = i_write && (!o_full || do_read);

   // head is read straight from the array
   assign o_item = mem[rd_ptr];

   // next occupancy from the accepted operations
   always_comb begin
      case ({do_write, do_read})
         2'b10:   occ_next = occupancy + 1'b1;  // write only
         2'b01:   occ_next = occupancy - 1'b1;  // read only
         default: occ_next = occupancy;         // both or neither
      endcase
   end

   // storage, only the preload slots are cleared
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < PRELOAD; i++) begin
            mem[i] <= '0;  // zero tuples form the initial lag
         end
      end else if (do_write) begin
         mem[wr_ptr] <= i_item;
      end
   end

   // write pointer starts behind the preload
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= ptr_t'(PRELOAD);
      end else if (do_write) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rd_ptr <= '0;
      end else if (do_read) begin
         rd_ptr <= rd_ptr + 1'b1;  // head moves at the edge
      end
   end

   // occupancy and registered flags, exact every cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         occupancy <= occ_t'(PRELOAD);
         o_empty   <= (PRELOAD == 0);
         o_full    <= 1'b0;             // preload is always below depth
      end else begin
         occupancy <= occ_next;
         o_empty   <= (occ_next == '0);
         o_full    <= (occ_next == occ_t'(DEPTH));
      end
   end

   // dropped write flags on the next cycle
   // when full the FIFO is never empty, so i_read alone decides
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_overrun <= 1'b0;
      end else begin
         o_overrun <= i_write && o_full && !i_read;
      end
   end

endmodule

`default_nettype wire

/* hw/tuple_pkg.sv */
`default_nettype none

// shared types for the tuple lag pairer
package tuple_pkg;

   localparam int ELEM_W  = 64;  // width of one tuple element
   localparam int COUNT_W = 16;  // joined-tuple counter width

   // one tuple element, plain unsigned vector
   typedef logic [ELEM_W-1:0] elem_t;

   // counter of joined tuples, wraps at 2^COUNT_W
   typedef logic [COUNT_W-1:0] count_t;

   // input tuple and FIFO item, e1 sits in the upper half
   typedef struct packed {
      elem_t e1;
      elem_t e0;
   } tuple_t;

   // joined output, each element is a 64-bit wrapping sum
   typedef struct packed {
      elem_t s1;
      elem_t s0;
   } sum_t;

   // sticky overrun flags, one per input stream
   typedef struct packed {
      logic b_overrun;  // stream b dropped a write
      logic a_overrun;  // stream a dropped a write
   } ovr_flags_t;

endpackage

`default_nettype wire
